//--- design/axi_pkg.sv
package axi_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] data_t;  // one data beat
  typedef logic [3:0] strb_t;  // one strobe bit per data byte
  typedef logic [3:0] id_t;
  typedef logic [7:0] len_t;  // beats in the burst minus one
  typedef logic [2:0] size_t;  // log2 of the bytes per beat
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  // response codes
  localparam resp_t resp_okay = 2'b00;

  // burst type codes, INCR is the only other one the memory sees
  localparam burst_t burst_fixed = 2'b00;
  localparam burst_t burst_incr = 2'b01;

  localparam int max_beats = 8;  // longest burst the delayer can buffer

endpackage

//--- design/delay_pkg.sv
package delay_pkg;

  // the slow region is decoded from the top nibble of the address
  localparam logic [3:0] region_low = 4'ha;  // first slow nibble
  localparam logic [3:0] region_high = 4'hc;  // first nibble past the region

  typedef logic [11:0] count_t;  // cycles since the address transfer

  // delayer FSM
  typedef enum logic [1:0] {
    st_idle,
    st_measure,
    st_hold,
    st_release
  } delay_state_t;

endpackage

//--- design/axi4_delayer.sv
`timescale 1ns/1ps

module axi4_delayer #(
  parameter int clock_ratio = 4  // bus clock over emulated memory clock
) (
  input logic clock,
  input logic reset,

  output logic in_arready,
  input logic in_arvalid,
  input axi_pkg::id_t in_arid,
  input axi_pkg::addr_t in_araddr,
  input axi_pkg::len_t in_arlen,
  input axi_pkg::size_t in_arsize,
  input axi_pkg::burst_t in_arburst,
  input logic in_rready,
  output logic in_rvalid,
  output axi_pkg::id_t in_rid,
  output axi_pkg::data_t in_rdata,
  output axi_pkg::resp_t in_rresp,
  output logic in_rlast,
  output logic in_awready,
  input logic in_awvalid,
  input axi_pkg::id_t in_awid,
  input axi_pkg::addr_t in_awaddr,
  input axi_pkg::len_t in_awlen,
  input axi_pkg::size_t in_awsize,
  input axi_pkg::burst_t in_awburst,
  output logic in_wready,
  input logic in_wvalid,
  input axi_pkg::data_t in_wdata,
  input axi_pkg::strb_t in_wstrb,
  input logic in_wlast,
  input logic in_bready,
  output logic in_bvalid,
  output axi_pkg::id_t in_bid,
  output axi_pkg::resp_t in_bresp,

  input logic out_arready,
  output logic out_arvalid,
  output axi_pkg::id_t out_arid,
  output axi_pkg::addr_t out_araddr,
  output axi_pkg::len_t out_arlen,
  output axi_pkg::size_t out_arsize,
  output axi_pkg::burst_t out_arburst,
  output logic out_rready,
  input logic out_rvalid,
  input axi_pkg::id_t out_rid,
  input axi_pkg::data_t out_rdata,
  input axi_pkg::resp_t out_rresp,
  input logic out_rlast,
  input logic out_awready,
  output logic out_awvalid,
  output axi_pkg::id_t out_awid,
  output axi_pkg::addr_t out_awaddr,
  output axi_pkg::len_t out_awlen,
  output axi_pkg::size_t out_awsize,
  output axi_pkg::burst_t out_awburst,
  input logic out_wready,
  output logic out_wvalid,
  output axi_pkg::data_t out_wdata,
  output axi_pkg::strb_t out_wstrb,
  output logic out_wlast,
  output logic out_bready,
  input logic out_bvalid,
  input axi_pkg::id_t out_bid,
  input axi_pkg::resp_t out_bresp
);

  localparam int ptr_w = $clog2(axi_pkg::max_beats);

  delay_pkg::delay_state_t state;
  logic pass_active;  // a fast-region transaction is in flight
  logic is_read;
  delay_pkg::count_t count;
  delay_pkg::count_t target;  // cycle at which the release starts
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] last_ptr;
  axi_pkg::data_t rdata_buf [axi_pkg::max_beats];
  axi_pkg::resp_t rresp_buf [axi_pkg::max_beats];
  axi_pkg::id_t rid_q;
  axi_pkg::id_t bid_q;
  axi_pkg::resp_t bresp_q;
  logic addr_open;
  logic ar_fire;
  logic aw_fire;
  logic down_done;
  logic up_done;

  function automatic logic in_slow_region(axi_pkg::addr_t addr);
    return addr[31:28] >= delay_pkg::region_low && addr[31:28] < delay_pkg::region_high;
  endfunction

  // only one transaction at a time, so addresses wait until everything is idle
  assign addr_open = (state == delay_pkg::st_idle) && !pass_active;

  assign out_arvalid = in_arvalid && addr_open;
  assign in_arready = out_arready && addr_open;
  assign out_arid = in_arid;
  assign out_araddr = in_araddr;
  assign out_arlen = in_arlen;
  assign out_arsize = in_arsize;
  assign out_arburst = in_arburst;

  assign out_awvalid = in_awvalid && addr_open;
  assign in_awready = out_awready && addr_open;
  assign out_awid = in_awid;
  assign out_awaddr = in_awaddr;
  assign out_awlen = in_awlen;
  assign out_awsize = in_awsize;
  assign out_awburst = in_awburst;

  assign out_wvalid = in_wvalid;  // write beats always go straight through
  assign in_wready = out_wready;
  assign out_wdata = in_wdata;
  assign out_wstrb = in_wstrb;
  assign out_wlast = in_wlast;

  assign ar_fire = out_arvalid && out_arready;
  assign aw_fire = out_awvalid && out_awready;

  // in idle the response channels are wired through, otherwise the buffer drives them
  always_comb begin
    if (state == delay_pkg::st_idle) begin
      in_rvalid = out_rvalid;
      in_rid = out_rid;
      in_rdata = out_rdata;
      in_rresp = out_rresp;
      in_rlast = out_rlast;
      out_rready = in_rready;
      in_bvalid = out_bvalid;
      in_bid = out_bid;
      in_bresp = out_bresp;
      out_bready = in_bready;
    end else begin
      in_rvalid = (state == delay_pkg::st_release) && is_read;
      in_rid = rid_q;
      in_rdata = rdata_buf[rd_ptr];
      in_rresp = rresp_buf[rd_ptr];
      in_rlast = rd_ptr == last_ptr;
      out_rready = state == delay_pkg::st_measure;  // drain the slave at full speed
      in_bvalid = (state == delay_pkg::st_release) && !is_read;
      in_bid = bid_q;
      in_bresp = bresp_q;
      out_bready = state == delay_pkg::st_measure;
    end
  end

  assign down_done = (state == delay_pkg::st_measure) &&
                     (is_read ? (out_rvalid && out_rlast) : out_bvalid);
  assign up_done = is_read ? (in_rvalid && in_rready && in_rlast) : (in_bvalid && in_bready);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= delay_pkg::st_idle;
      pass_active <= 1'b0;
      is_read <= 1'b0;
      count <= '0;
      target <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      last_ptr <= '0;
    end else begin
      case (state)
        delay_pkg::st_idle: begin
          if (ar_fire || aw_fire) begin
            is_read <= ar_fire;
            count <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            if (ar_fire) begin
              last_ptr <= in_arlen[ptr_w-1:0];
            end
            if ((ar_fire && in_slow_region(in_araddr)) ||
                (aw_fire && in_slow_region(in_awaddr))) begin
              state <= delay_pkg::st_measure;
            end else begin
              pass_active <= 1'b1;
            end
          end else if (pass_active && up_done) begin
            pass_active <= 1'b0;
          end
        end
        delay_pkg::st_measure: begin
          count <= count + 1'b1;
          if (is_read && out_rvalid) begin
            wr_ptr <= wr_ptr + 1'b1;
          end
          if (down_done) begin
            // count + 1 is the measured latency, this edge included
            target <= delay_pkg::count_t'((count + 1'b1) * clock_ratio);
            state <= (clock_ratio == 1) ? delay_pkg::st_release : delay_pkg::st_hold;
          end
        end
        delay_pkg::st_hold: begin
          count <= count + 1'b1;
          if (count + 1'b1 == target) begin
            state <= delay_pkg::st_release;
          end
        end
        delay_pkg::st_release: begin
          if (in_rvalid && in_rready) begin
            rd_ptr <= rd_ptr + 1'b1;
          end
          if (up_done) begin
            state <= delay_pkg::st_idle;
          end
        end
        default: state <= delay_pkg::st_idle;
      endcase
    end
  end

  // response capture while the slave is being measured
  always_ff @(posedge clock) begin
    if (state == delay_pkg::st_measure && is_read && out_rvalid) begin
      rdata_buf[wr_ptr] <= out_rdata;
      rresp_buf[wr_ptr] <= out_rresp;
      rid_q <= out_rid;
    end
    if (state == delay_pkg::st_measure && !is_read && out_bvalid) begin
      bid_q <= out_bid;
      bresp_q <= out_bresp;
    end
  end

endmodule

//--- design/axi4_sram.sv
`timescale 1ns/1ps

module axi4_sram #(
  parameter int mem_words = 1024  // must be a power of two
) (
  input logic clock,
  input logic reset,

  output logic arready,
  input logic arvalid,
  input axi_pkg::id_t arid,
  input axi_pkg::addr_t araddr,
  input axi_pkg::len_t arlen,
  input axi_pkg::size_t arsize,
  input axi_pkg::burst_t arburst,
  input logic rready,
  output logic rvalid,
  output axi_pkg::id_t rid,
  output axi_pkg::data_t rdata,
  output axi_pkg::resp_t rresp,
  output logic rlast,
  output logic awready,
  input logic awvalid,
  input axi_pkg::id_t awid,
  input axi_pkg::addr_t awaddr,
  input axi_pkg::len_t awlen,
  input axi_pkg::size_t awsize,
  input axi_pkg::burst_t awburst,
  output logic wready,
  input logic wvalid,
  input axi_pkg::data_t wdata,
  input axi_pkg::strb_t wstrb,
  input logic wlast,
  input logic bready,
  output logic bvalid,
  output axi_pkg::id_t bid,
  output axi_pkg::resp_t bresp
);

  localparam int idx_w = $clog2(mem_words);
  localparam int lanes = $bits(axi_pkg::strb_t);
  localparam int off_w = $clog2(lanes);  // byte offset bits inside a word

  typedef enum logic [2:0] {
    sram_idle,
    sram_rd_wait,
    sram_rd_load,
    sram_rd_data,
    sram_wr_data,
    sram_wr_wait,
    sram_wr_resp
  } sram_state_t;

  sram_state_t state;
  axi_pkg::len_t beat;  // beats done in the current burst
  axi_pkg::len_t len_q;
  axi_pkg::addr_t addr_q;
  axi_pkg::size_t size_q;
  axi_pkg::burst_t burst_q;
  axi_pkg::id_t id_q;
  axi_pkg::data_t rdata_q;
  axi_pkg::data_t mem [mem_words];
  axi_pkg::addr_t next_addr;
  logic ar_fire;
  logic aw_fire;
  logic r_fire;
  logic w_fire;

  function automatic logic [idx_w-1:0] word_idx(axi_pkg::addr_t addr);
    return addr[off_w +: idx_w];  // upper bits drop out, so the memory wraps
  endfunction

  assign arready = state == sram_idle;
  assign awready = (state == sram_idle) && !arvalid;  // reads win a tie
  assign wready = state == sram_wr_data;
  assign rvalid = state == sram_rd_data;
  assign bvalid = state == sram_wr_resp;

  assign rid = id_q;
  assign rdata = rdata_q;
  assign rresp = axi_pkg::resp_okay;
  assign rlast = beat == len_q;
  assign bid = id_q;
  assign bresp = axi_pkg::resp_okay;

  assign ar_fire = arvalid && arready;
  assign aw_fire = awvalid && awready;
  assign r_fire = rvalid && rready;
  assign w_fire = wvalid && wready;

  assign next_addr = (burst_q == axi_pkg::burst_fixed) ?
                     addr_q : addr_q + (axi_pkg::addr_t'(1) << size_q);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= sram_idle;
      beat <= '0;
    end else begin
      case (state)
        sram_idle: begin
          beat <= '0;
          if (ar_fire) begin
            state <= sram_rd_wait;
          end else if (aw_fire) begin
            state <= sram_wr_data;
          end
        end
        sram_rd_wait: state <= sram_rd_load;
        sram_rd_load: state <= sram_rd_data;  // first beat shows two cycles after AR
        sram_rd_data: begin
          if (r_fire && rlast) begin
            state <= sram_idle;
          end else if (r_fire) begin
            beat <= beat + 1'b1;
          end
        end
        sram_wr_data: begin
          if (w_fire) begin
            beat <= beat + 1'b1;
          end
          if (w_fire && (wlast || beat == len_q)) begin
            state <= sram_wr_wait;
          end
        end
        sram_wr_wait: state <= sram_wr_resp;
        sram_wr_resp: begin
          if (bready) begin
            state <= sram_idle;
          end
        end
        default: state <= sram_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      addr_q <= araddr;
      len_q <= arlen;
      size_q <= arsize;
      burst_q <= arburst;
      id_q <= arid;
    end else if (aw_fire) begin
      addr_q <= awaddr;
      len_q <= awlen;
      size_q <= awsize;
      burst_q <= awburst;
      id_q <= awid;
    end
    if (state == sram_rd_load) begin
      rdata_q <= mem[word_idx(addr_q)];
    end
    if (r_fire && !rlast) begin
      rdata_q <= mem[word_idx(next_addr)];  // next beat is ready the cycle after
      addr_q <= next_addr;
    end
    if (w_fire) begin
      for (int i = 0; i < lanes; i++) begin
        if (wstrb[i]) begin
          mem[word_idx(addr_q)][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
      addr_q <= next_addr;
    end
  end

endmodule

//--- design/axi_delay_top.sv
`timescale 1ns/1ps

module axi_delay_top #(
  parameter int clock_ratio = 4,  // how many times slower the slow region looks
  parameter int mem_words = 1024
) (
  input logic clock,
  input logic reset,

  output logic in_arready,
  input logic in_arvalid,
  input axi_pkg::id_t in_arid,
  input axi_pkg::addr_t in_araddr,
  input axi_pkg::len_t in_arlen,
  input axi_pkg::size_t in_arsize,
  input axi_pkg::burst_t in_arburst,
  input logic in_rready,
  output logic in_rvalid,
  output axi_pkg::id_t in_rid,
  output axi_pkg::data_t in_rdata,
  output axi_pkg::resp_t in_rresp,
  output logic in_rlast,
  output logic in_awready,
  input logic in_awvalid,
  input axi_pkg::id_t in_awid,
  input axi_pkg::addr_t in_awaddr,
  input axi_pkg::len_t in_awlen,
  input axi_pkg::size_t in_awsize,
  input axi_pkg::burst_t in_awburst,
  output logic in_wready,
  input logic in_wvalid,
  input axi_pkg::data_t in_wdata,
  input axi_pkg::strb_t in_wstrb,
  input logic in_wlast,
  input logic in_bready,
  output logic in_bvalid,
  output axi_pkg::id_t in_bid,
  output axi_pkg::resp_t in_bresp
);

  // link between the delayer and the memory
  logic mem_arready, mem_arvalid, mem_rready, mem_rvalid, mem_rlast;
  logic mem_awready, mem_awvalid, mem_wready, mem_wvalid, mem_wlast;
  logic mem_bready, mem_bvalid;
  axi_pkg::id_t mem_arid, mem_rid, mem_awid, mem_bid;
  axi_pkg::addr_t mem_araddr, mem_awaddr;
  axi_pkg::len_t mem_arlen, mem_awlen;
  axi_pkg::size_t mem_arsize, mem_awsize;
  axi_pkg::burst_t mem_arburst, mem_awburst;
  axi_pkg::data_t mem_rdata, mem_wdata;
  axi_pkg::resp_t mem_rresp, mem_bresp;
  axi_pkg::strb_t mem_wstrb;

  axi4_delayer #(.clock_ratio(clock_ratio)) i_axi4_delayer (
    .*,  // clock, reset and the whole upstream port share their names
    .out_arready(mem_arready), .out_arvalid(mem_arvalid), .out_arid(mem_arid),
    .out_araddr(mem_araddr), .out_arlen(mem_arlen), .out_arsize(mem_arsize),
    .out_arburst(mem_arburst),
    .out_rready(mem_rready), .out_rvalid(mem_rvalid), .out_rid(mem_rid),
    .out_rdata(mem_rdata), .out_rresp(mem_rresp), .out_rlast(mem_rlast),
    .out_awready(mem_awready), .out_awvalid(mem_awvalid), .out_awid(mem_awid),
    .out_awaddr(mem_awaddr), .out_awlen(mem_awlen), .out_awsize(mem_awsize),
    .out_awburst(mem_awburst),
    .out_wready(mem_wready), .out_wvalid(mem_wvalid), .out_wdata(mem_wdata),
    .out_wstrb(mem_wstrb), .out_wlast(mem_wlast),
    .out_bready(mem_bready), .out_bvalid(mem_bvalid), .out_bid(mem_bid),
    .out_bresp(mem_bresp)
  );

  axi4_sram #(.mem_words(mem_words)) i_axi4_sram (
    .clock(clock), .reset(reset),
    .arready(mem_arready), .arvalid(mem_arvalid), .arid(mem_arid),
    .araddr(mem_araddr), .arlen(mem_arlen), .arsize(mem_arsize), .arburst(mem_arburst),
    .rready(mem_rready), .rvalid(mem_rvalid), .rid(mem_rid),
    .rdata(mem_rdata), .rresp(mem_rresp), .rlast(mem_rlast),
    .awready(mem_awready), .awvalid(mem_awvalid), .awid(mem_awid),
    .awaddr(mem_awaddr), .awlen(mem_awlen), .awsize(mem_awsize), .awburst(mem_awburst),
    .wready(mem_wready), .wvalid(mem_wvalid), .wdata(mem_wdata),
    .wstrb(mem_wstrb), .wlast(mem_wlast),
    .bready(mem_bready), .bvalid(mem_bvalid), .bid(mem_bid), .bresp(mem_bresp)
  );

endmodule

//--- testbench/axi_delay_ref.svh
`ifndef AXI_DELAY_REF_SVH
`define AXI_DELAY_REF_SVH

// byte model of the memory, wraps at mem_words words like the DUT memory
logic [7:0] ref_mem [mem_words * 4];

function automatic int ref_word(axi_pkg::addr_t addr);
  return int'((addr >> 2) % axi_pkg::addr_t'(mem_words));
endfunction

// fill data mixes every address bit so that aliasing shows up
function automatic axi_pkg::data_t fill_word(axi_pkg::addr_t addr);
  return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
endfunction

function automatic void model_write(axi_pkg::addr_t addr, axi_pkg::data_t data,
                                    axi_pkg::strb_t strb);
  int base;
  base = ref_word(addr) * 4;
  for (int i = 0; i < 4; i++) begin
    if (strb[i]) begin
      ref_mem[base + i] = data[8*i +: 8];
    end
  end
endfunction

function automatic axi_pkg::data_t model_read(axi_pkg::addr_t addr);
  int base;
  base = ref_word(addr) * 4;
  return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
endfunction

function automatic bit slow_region(axi_pkg::addr_t addr);
  return addr >= 32'ha000_0000 && addr < 32'hc000_0000;
endfunction

// first rvalid after the AR transfer; outside the region only the memory's two cycles count
function automatic int expected_latency(axi_pkg::addr_t addr, int len);
  return slow_region(addr) ? clock_ratio * (len + 3) : 2;
endfunction

`endif

//--- testbench/axi_delay_tb.sv
`timescale 1ns/1ps

module axi_delay_tb;

  localparam int clock_ratio = 4;
  localparam int mem_words = 1024;
  localparam int num_random = 200;
  localparam int num_trans = num_random + 30;  // the directed tests use fewer than 30
  localparam int watchdog_cycles = num_trans * axi_pkg::max_beats * clock_ratio * 40;

  logic clock = 1'b0;
  logic reset;
  logic in_arready, in_arvalid, in_rready, in_rvalid, in_rlast;
  logic in_awready, in_awvalid, in_wready, in_wvalid, in_wlast;
  logic in_bready, in_bvalid;
  axi_pkg::id_t in_arid, in_rid, in_awid, in_bid;
  axi_pkg::addr_t in_araddr, in_awaddr;
  axi_pkg::len_t in_arlen, in_awlen;
  axi_pkg::size_t in_arsize, in_awsize;
  axi_pkg::burst_t in_arburst, in_awburst;
  axi_pkg::data_t in_rdata, in_wdata;
  axi_pkg::resp_t in_rresp, in_bresp;
  axi_pkg::strb_t in_wstrb;

  int cycle = 0;
  int errors = 0;
  int checks = 0;
  int errors_before = 0;
  logic stall_enable = 1'b0;  // random low cycles on rready and bready
  axi_pkg::data_t exp_data [$];  // beats still owed by the current read
  axi_pkg::id_t exp_id;
  int exp_len;
  int exp_latency;
  int beat_idx;
  int ar_cycle;
  int last_beat_cycle;
  logic first_pending = 1'b0;
  logic b_owed = 1'b0;  // a write still waits for its response

  `include "axi_delay_ref.svh"

  axi_delay_top #(.clock_ratio(clock_ratio), .mem_words(mem_words)) i_axi_delay_top (.*);

  always #4 clock = ~clock;

  always @(posedge clock) cycle <= cycle + 1;

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    assert (got === expected) else begin
      $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, got);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // the word index stays inside the filled window and the top nibble picks the region
  function automatic axi_pkg::addr_t random_addr();
    axi_pkg::addr_t addr;
    addr = $urandom() & 32'hffff_f07c;
    if ($urandom_range(0, 1) == 1) begin
      addr[31:28] = 4'ha + 4'($urandom_range(0, 1));
    end
    return addr;
  endfunction

  task automatic write_burst(input axi_pkg::addr_t addr, input int len, input axi_pkg::id_t id,
                             input bit fill);
    axi_pkg::data_t data;
    axi_pkg::strb_t strb;
    int aw_cycle;
    int b_latency;
    b_owed = 1'b1;
    in_awvalid = 1'b1;
    in_awaddr = addr;
    in_awid = id;
    in_awlen = axi_pkg::len_t'(len);
    in_awsize = 3'd2;
    in_awburst = axi_pkg::burst_incr;
    @(negedge clock);
    while (!in_awready) @(negedge clock);
    aw_cycle = cycle;
    @(posedge clock);
    #1;
    in_awvalid = 1'b0;
    for (int i = 0; i <= len; i++) begin
      data = fill ? fill_word(addr + 4 * i) : $urandom();
      strb = fill ? 4'hf : axi_pkg::strb_t'($urandom_range(0, 15));
      in_wvalid = 1'b1;
      in_wdata = data;
      in_wstrb = strb;
      in_wlast = (i == len);
      @(negedge clock);
      while (!in_wready) @(negedge clock);
      model_write(addr + 4 * i, data, strb);
      @(posedge clock);
      #1;
    end
    in_wvalid = 1'b0;
    in_wlast = 1'b0;
    @(negedge clock);
    while (!in_bvalid) @(negedge clock);
    b_latency = cycle - aw_cycle - 1;
    while (!in_bready) @(negedge clock);
    check_equal("in_bid", 32'(in_bid), 32'(id));
    check_equal("in_bresp", 32'(in_bresp), 32'(axi_pkg::resp_okay));
    checks++;
    assert (b_latency >= expected_latency(addr, len)) else begin
      $display("FAIL t=%0t in_bvalid latency expected at least %0d got %0d", $time,
               expected_latency(addr, len), b_latency);
      errors++;
    end
    @(posedge clock);
    #1;
  endtask

  task automatic read_burst(input axi_pkg::addr_t addr, input int len, input axi_pkg::id_t id);
    for (int i = 0; i <= len; i++) begin
      exp_data.push_back(model_read(addr + 4 * i));
    end
    exp_id = id;
    exp_len = len;
    exp_latency = expected_latency(addr, len);
    beat_idx = 0;
    in_arvalid = 1'b1;
    in_araddr = addr;
    in_arid = id;
    in_arlen = axi_pkg::len_t'(len);
    in_arsize = 3'd2;
    in_arburst = axi_pkg::burst_incr;
    @(negedge clock);
    while (!in_arready) @(negedge clock);
    @(posedge clock);
    #1;
    in_arvalid = 1'b0;
    do @(posedge clock); while (exp_data.size() != 0);
    #1;
  endtask

  // the response channels are compared at the falling edge where everything is settled
  always @(negedge clock) begin
    if (in_arvalid && in_arready) begin
      ar_cycle = cycle;
      first_pending = 1'b1;
    end
    if (in_rvalid && first_pending) begin
      check_equal("in_rvalid latency", cycle - ar_cycle - 1, exp_latency);
      first_pending = 1'b0;
    end
    if (in_rvalid && in_rready) begin
      checks++;
      assert (exp_data.size() != 0) else begin
        $display("FAIL t=%0t an R beat arrived that no read asked for", $time);
        errors++;
      end
      if (exp_data.size() != 0) begin
        check_equal("in_rdata", in_rdata, exp_data[0]);
        check_equal("in_rid", 32'(in_rid), 32'(exp_id));
        check_equal("in_rresp", 32'(in_rresp), 32'(axi_pkg::resp_okay));
        check_equal("in_rlast", 32'(in_rlast), 32'(beat_idx == exp_len));
        if (!stall_enable && beat_idx != 0) begin
          check_equal("in_rvalid beat gap", cycle - last_beat_cycle, 32'd1);
        end
        void'(exp_data.pop_front());
        last_beat_cycle = cycle;
        beat_idx++;
      end
    end
    if (in_bvalid && in_bready) begin
      checks++;
      assert (b_owed) else begin
        $display("FAIL t=%0t a B response arrived that no write asked for", $time);
        errors++;
      end
      b_owed = 1'b0;
    end
  end

  initial begin
    in_rready = 1'b1;
    in_bready = 1'b1;
    forever begin
      @(posedge clock);
      #1;
      in_rready = !stall_enable || ($urandom_range(0, 3) != 0);
      in_bready = !stall_enable || ($urandom_range(0, 3) != 0);
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    axi_pkg::addr_t addr;
    int len;
    void'($urandom(82));
    {in_arvalid, in_arid, in_araddr, in_arlen, in_arsize, in_arburst} = '0;
    {in_awvalid, in_awid, in_awaddr, in_awlen, in_awsize, in_awburst} = '0;
    {in_wvalid, in_wdata, in_wstrb, in_wlast} = '0;
    reset = 1'b1;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    @(negedge clock);
    check_equal("in_rvalid", 32'(in_rvalid), 32'd0);
    check_equal("in_bvalid", 32'(in_bvalid), 32'd0);
    check_equal("in_wready", 32'(in_wready), 32'd0);
    check_equal("in_arready", 32'(in_arready), 32'd1);  // memory waits for an address
    check_equal("in_awready", 32'(in_awready), 32'd1);
    finish_test("reset");
    @(posedge clock);
    #1;

    for (int i = 0; i < 6; i++) begin
      write_burst(32 * i, 7, axi_pkg::id_t'(i), 1'b1);
    end
    finish_test("fill");

    write_burst(32'h0000_0010, 0, 4'h1, 1'b0);
    write_burst(32'h1000_0020, 7, 4'h2, 1'b0);
    write_burst(32'h9000_0044, 0, 4'h3, 1'b0);
    write_burst(32'h7fff_f060, 7, 4'h4, 1'b0);
    read_burst(32'h0000_0010, 0, 4'h5);
    read_burst(32'h1000_0020, 7, 4'h6);
    read_burst(32'h9000_0044, 0, 4'h7);
    read_burst(32'h7fff_f060, 7, 4'h8);
    finish_test("pass-through");

    read_burst(32'ha000_0040, 7, 4'h9);
    read_burst(32'hbfff_f004, 0, 4'ha);
    finish_test("slow read latency");

    write_burst(32'ha000_0080, 3, 4'hb, 1'b0);
    read_burst(32'hb000_0080, 3, 4'hc);
    finish_test("slow write");

    stall_enable = 1'b1;
    read_burst(32'ha000_0000, 7, 4'hd);
    write_burst(32'hb000_0020, 7, 4'he, 1'b0);
    read_burst(32'ha000_0020, 7, 4'hf);
    read_burst(32'h0000_0020, 5, 4'h0);
    finish_test("back-pressure");

    for (int n = 0; n < num_random; n++) begin
      addr = random_addr();
      len = $urandom_range(0, 7);
      if ($urandom_range(0, 1) == 1) begin
        write_burst(addr, len, axi_pkg::id_t'($urandom_range(0, 15)), 1'b0);
      end else begin
        read_burst(addr, len, axi_pkg::id_t'($urandom_range(0, 15)));
      end
    end
    stall_enable = 1'b0;
    finish_test("random mix");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- axi_delay_top.f
+incdir+testbench
design/axi_pkg.sv
design/delay_pkg.sv
design/axi4_delayer.sv
design/axi4_sram.sv
design/axi_delay_top.sv
testbench/axi_delay_tb.sv

//--- Bender.yml
package:
  name: axi_delay

sources:
  - design/axi_pkg.sv
  - design/delay_pkg.sv
  - design/axi4_delayer.sv
  - design/axi4_sram.sv
  - design/axi_delay_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/axi_delay_tb.sv
